/* logic/mpf_csr_pkg.sv */
/*
 * CSR read manager definitions: MMIO window map, widths, feature UIDs,
 * statistics placement and the initial CSR contents
 */
package mpf_csr_pkg;

    // MMIO request fields from the host
    localparam int MMIO_ADDR_W = 16;
    localparam int TID_W = 9;
    typedef logic [MMIO_ADDR_W-1:0] t_mmio_addr;
    typedef logic [TID_W-1:0] t_tid;

    // Byte base of the managed window, dword base is 'h400
    localparam int DFH_MMIO_BASE_ADDR = 'h1000;
    localparam int INSTANCE_ID = 1;

    // ====================================================================
    // Window layout
    // ====================================================================

    localparam int NUM_FEATURES = 4;
    // 16 words per feature, 128 bytes
    localparam int FEATURE_SIZE64 = 16;
    localparam int CSR_SIZE64 = 64;
    typedef logic [$clog2(CSR_SIZE64)-1:0] t_csr_offset;

    localparam int CSR_WORD_W = 64;
    typedef logic [CSR_WORD_W-1:0] t_csr_word;

    // Word positions inside one feature
    localparam int DFH_WORD = 0;
    localparam int UID_L_WORD = 1;
    localparam int UID_H_WORD = 2;
    localparam int STAT_WORD = 8;

    // Feature slots, in list order
    localparam int FEAT_VTP = 0;
    localparam int FEAT_VC_MAP = 2;
    localparam int FEAT_WRO = 3;

    // UIDs in list order: VTP, RSP_ORDER, VC_MAP, WRO
    localparam logic [127:0] FEATURE_UID [NUM_FEATURES] = '{
        128'hc8a2982f_ff96_42bf_a705_45727f501901,
        128'h4c9c96f4_65ba_4dd8_b383_c70ace57bfe4,
        128'h5046c86f_ba48_4856_b8f9_3b76e3dd4e74,
        128'h56b06b48_9dd7_4004_a47e_0681b4207a6d
    };
    localparam bit FEATURE_ENABLE [NUM_FEATURES] = '{1'b1, 1'b1, 1'b1, 1'b1};

    // ====================================================================
    // Statistics
    // ====================================================================

    localparam int NUM_STATS = 7;
    localparam int STAT_CNT_W = 16;
    typedef logic [STAT_CNT_W-1:0] t_stat_cnt;
    typedef t_stat_cnt [NUM_STATS-1:0] t_stat_cnt_vec;

    // Six VTP counters, then the VC map change counter
    localparam t_csr_offset STAT_OFFSET [NUM_STATS] = '{
        t_csr_offset'(FEAT_VTP * FEATURE_SIZE64 + STAT_WORD + 0),
        t_csr_offset'(FEAT_VTP * FEATURE_SIZE64 + STAT_WORD + 1),
        t_csr_offset'(FEAT_VTP * FEATURE_SIZE64 + STAT_WORD + 2),
        t_csr_offset'(FEAT_VTP * FEATURE_SIZE64 + STAT_WORD + 3),
        t_csr_offset'(FEAT_VTP * FEATURE_SIZE64 + STAT_WORD + 4),
        t_csr_offset'(FEAT_VTP * FEATURE_SIZE64 + STAT_WORD + 5),
        t_csr_offset'(FEAT_VC_MAP * FEATURE_SIZE64 + STAT_WORD)
    };

    localparam int STAT_FLUSH_INTERVAL_LOG2 = 10;

    // Initial content of one 64-bit CSR word
    function automatic t_csr_word csr_init_word(t_csr_offset idx);
        int feat;
        int word;
        logic [127:0] uid;
        t_csr_word w;

        feat = int'(idx) / FEATURE_SIZE64;
        word = int'(idx) % FEATURE_SIZE64;
        // Disabled features report a null UID
        uid = FEATURE_ENABLE[feat] ? FEATURE_UID[feat] : '0;
        w = '0;

        case (word)
            DFH_WORD:
            begin
                // BBB type, next header one feature further on
                w[63:60] = 4'h2;
                w[40] = (feat == FEAT_WRO);
                w[39:16] = 24'(FEATURE_SIZE64 * 8);
                w[11:0] = 12'(INSTANCE_ID);
            end
            UID_L_WORD: w = uid[63:0];
            UID_H_WORD: w = uid[127:64];
            default: w = '0;
        endcase

        return w;
    endfunction

endpackage

/* logic/mmio_req_fifo.sv */
/*
 * MMIO read request buffer: window check, registered enqueue and a
 * FIFO of pending reads behind a registered head
 */
`timescale 1ns/1ps

module mmio_req_fifo
#(
    parameter int DEPTH = 64
)
(
    input  logic clk,
    input  logic reset,

    input  logic mmio_rd_valid,
    input  mpf_csr_pkg::t_mmio_addr mmio_rd_addr,
    input  mpf_csr_pkg::t_tid mmio_rd_tid,

    input  logic req_deq,
    output logic req_valid,
    output mpf_csr_pkg::t_csr_offset req_offset,
    output mpf_csr_pkg::t_tid req_tid
);

    localparam int AW = $clog2(DEPTH);
    localparam int BASE_DW = mpf_csr_pkg::DFH_MMIO_BASE_ADDR >> 2;
    // Two dwords per 64-bit word
    localparam int LAST_DW = BASE_DW + mpf_csr_pkg::CSR_SIZE64 * 2;

    // Dword address relative to the window base
    mpf_csr_pkg::t_mmio_addr addr_rel;
    logic in_range;

    assign addr_rel = mmio_rd_addr - mpf_csr_pkg::t_mmio_addr'(BASE_DW);
    assign in_range = (mmio_rd_addr >= mpf_csr_pkg::t_mmio_addr'(BASE_DW)) &&
                      (mmio_rd_addr < mpf_csr_pkg::t_mmio_addr'(LAST_DW));

    // Registered enqueue stage
    logic in_valid_q;
    mpf_csr_pkg::t_csr_offset in_offset_q;
    mpf_csr_pkg::t_tid in_tid_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            in_valid_q <= 1'b0;
        else
            in_valid_q <= mmio_rd_valid && in_range;

        // Drop the low dword bit to get the 64-bit word index
        in_offset_q <= addr_rel[1 +: $bits(mpf_csr_pkg::t_csr_offset)];
        in_tid_q <= mmio_rd_tid;
    end

    // ====================================================================
    // Storage behind the head register
    // ====================================================================

    mpf_csr_pkg::t_csr_offset mem_offset [DEPTH];
    mpf_csr_pkg::t_tid mem_tid [DEPTH];
    // Extra pointer bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic mem_empty;
    logic head_free;
    logic bypass;

    assign mem_empty = (wr_ptr == rd_ptr);
    // Head slot is open after this cycle
    assign head_free = !req_valid || req_deq;
    // New entry goes straight to the head when nothing waits ahead of it
    assign bypass = head_free && mem_empty && in_valid_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            req_valid <= 1'b0;
        end
        else
        begin
            if (in_valid_q && !bypass)
                wr_ptr <= wr_ptr + 1'b1;

            if (head_free)
            begin
                req_valid <= !mem_empty || in_valid_q;
                if (!mem_empty)
                    rd_ptr <= rd_ptr + 1'b1;
            end
        end

        if (in_valid_q && !bypass)
        begin
            mem_offset[wr_ptr[AW-1:0]] <= in_offset_q;
            mem_tid[wr_ptr[AW-1:0]] <= in_tid_q;
        end

        // Head payload, oldest entry first
        if (head_free)
        begin
            req_offset <= mem_empty ? in_offset_q : mem_offset[rd_ptr[AW-1:0]];
            req_tid <= mem_empty ? in_tid_q : mem_tid[rd_ptr[AW-1:0]];
        end
    end

endmodule

/* logic/csr_stat_accum.sv */
/*
 * Event accumulators: one 16-bit counter per event input and a
 * periodic flush strobe toward the read engine
 */
`timescale 1ns/1ps

module csr_stat_accum
(
    input  logic clk,
    input  logic reset,

    input  logic [mpf_csr_pkg::NUM_STATS-1:0] events,

    // Engine can take a new count vector
    input  logic stat_rdy,
    output logic stat_upd_en,
    output mpf_csr_pkg::t_stat_cnt_vec stat_counts
);

    localparam int LOG2 = mpf_csr_pkg::STAT_FLUSH_INTERVAL_LOG2;

    // ====================================================================
    // Flush interval
    // ====================================================================

    // Top bit set once the interval has elapsed
    logic [LOG2:0] interval_cnt;

    // Hand over as soon as the interval is up and the engine is idle
    assign stat_upd_en = interval_cnt[LOG2] && stat_rdy;

    always_ff @(posedge clk)
    begin
        if (reset)
            interval_cnt <= '0;
        else if (stat_upd_en)
            interval_cnt <= '0;
        else if (!interval_cnt[LOG2])
            interval_cnt <= interval_cnt + 1'b1;
        // Otherwise hold and wait for stat_rdy
    end

    // ====================================================================
    // Accumulators
    // ====================================================================

    // Events pass through a register first
    logic [mpf_csr_pkg::NUM_STATS-1:0] events_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            events_q <= '0;
            stat_counts <= '0;
        end
        else
        begin
            events_q <= events;

            for (int i = 0; i < mpf_csr_pkg::NUM_STATS; i++)
            begin
                // Restart from zero on handover, still adding this cycle's event
                stat_counts[i] <= (stat_upd_en ? '0 : stat_counts[i]) +
                                  mpf_csr_pkg::t_stat_cnt'(events_q[i]);
            end
        end
    end

endmodule

/* logic/csr_rd_memory.sv */
/*
 * CSR store: 64-bit words held in a double-pumped 32-bit RAM, with a
 * post-reset initialization sweep from the feature header table
 */
`timescale 1ns/1ps

module csr_rd_memory
(
    input  logic clk,
    input  logic reset,

    input  logic mem_rd_en,
    input  mpf_csr_pkg::t_csr_offset mem_rd_idx,
    output logic mem_rd_rdy,

    output mpf_csr_pkg::t_csr_word mem_rd_val,
    output logic mem_rd_val_valid,

    input  logic mem_wr_en,
    input  mpf_csr_pkg::t_csr_offset mem_wr_idx,
    input  mpf_csr_pkg::t_csr_word mem_wr_val,
    output logic mem_wr_rdy
);

    localparam int RAM_ENTRIES = mpf_csr_pkg::CSR_SIZE64 * 2;

    // Low half at even address, high half at odd
    logic [31:0] ram [RAM_ENTRIES];

    // ====================================================================
    // Write port
    // ====================================================================

    logic initialized;
    mpf_csr_pkg::t_csr_offset init_idx;
    mpf_csr_pkg::t_csr_word init_word;

    logic wen;
    // Second cycle of a 64-bit write
    logic waddr_upper;
    mpf_csr_pkg::t_csr_offset waddr;
    logic [31:0] wdata;

    // High half and index held for the second write cycle
    mpf_csr_pkg::t_csr_offset wr_idx_q;
    logic [31:0] wr_high_q;

    assign init_word = mpf_csr_pkg::csr_init_word(init_idx);

    assign mem_wr_rdy = initialized && !waddr_upper;

    always_comb
    begin
        wen = mem_wr_en || waddr_upper || !initialized;

        if (!initialized)
        begin
            // Sweep writes low then high half of each word
            waddr = init_idx;
            wdata = waddr_upper ? init_word[63:32] : init_word[31:0];
        end
        else if (waddr_upper)
        begin
            waddr = wr_idx_q;
            wdata = wr_high_q;
        end
        else
        begin
            waddr = mem_wr_idx;
            wdata = mem_wr_val[31:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            waddr_upper <= 1'b0;
            initialized <= 1'b0;
            init_idx <= '0;
        end
        else
        begin
            waddr_upper <= waddr_upper ^ wen;

            // Advance the sweep after each high half
            if (!initialized && waddr_upper)
            begin
                init_idx <= init_idx + 1'b1;
                initialized <= (init_idx == mpf_csr_pkg::t_csr_offset'(
                                    mpf_csr_pkg::CSR_SIZE64 - 1));
            end
        end

        if (mem_wr_en)
        begin
            wr_idx_q <= mem_wr_idx;
            wr_high_q <= mem_wr_val[63:32];
        end

        if (wen)
            ram[{waddr, waddr_upper}] <= wdata;
    end

    // ====================================================================
    // Read port, two RAM stages then a 64-bit assembly
    // ====================================================================

    logic raddr_upper;
    mpf_csr_pkg::t_csr_offset rd_idx_q;
    mpf_csr_pkg::t_csr_offset raddr;
    logic [31:0] ram_q;
    logic [31:0] rdata;
    logic [31:0] rd_val_low;

    // One read in flight at a time
    logic rd_busy;
    logic rd_req_q;
    logic rd_req_qq;

    assign mem_rd_rdy = initialized && !rd_busy;
    assign raddr = raddr_upper ? rd_idx_q : mem_rd_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            raddr_upper <= 1'b0;
            rd_busy <= 1'b0;
            rd_req_q <= 1'b0;
            rd_req_qq <= 1'b0;
            mem_rd_val_valid <= 1'b0;
        end
        else
        begin
            raddr_upper <= mem_rd_en && !raddr_upper;

            if (mem_rd_en)
                rd_busy <= 1'b1;
            else if (mem_rd_val_valid)
                rd_busy <= 1'b0;

            // Value is complete 3 cycles after the request
            rd_req_q <= mem_rd_en;
            rd_req_qq <= rd_req_q;
            mem_rd_val_valid <= rd_req_qq;
        end

        if (mem_rd_en)
            rd_idx_q <= mem_rd_idx;

        // RAM read register plus output register
        ram_q <= ram[{raddr, raddr_upper}];
        rdata <= ram_q;

        // Low half shows up one cycle ahead of the high half
        if (rd_req_qq)
            rd_val_low <= rdata;
    end

    assign mem_rd_val = {rdata, rd_val_low};

endmodule

/* logic/csr_read_engine.sv */
/*
 * CSR read engine: serves buffered MMIO reads from the store and folds
 * accumulated event counts into the 64-bit statistics words
 */
`timescale 1ns/1ps

module csr_read_engine
(
    input  logic clk,
    input  logic reset,

    // Head of the request FIFO
    input  logic req_valid,
    input  mpf_csr_pkg::t_csr_offset req_offset,
    input  mpf_csr_pkg::t_tid req_tid,
    output logic req_deq,

    // Count vector from the accumulators
    input  logic stat_upd_en,
    input  mpf_csr_pkg::t_stat_cnt_vec stat_counts,
    output logic stat_rdy,

    // Store
    input  logic mem_rd_rdy,
    input  logic mem_wr_rdy,
    input  mpf_csr_pkg::t_csr_word mem_rd_val,
    input  logic mem_rd_val_valid,
    output logic mem_rd_en,
    output mpf_csr_pkg::t_csr_offset mem_rd_idx,
    output logic mem_wr_en,
    output mpf_csr_pkg::t_csr_offset mem_wr_idx,
    output mpf_csr_pkg::t_csr_word mem_wr_val,

    // Host response
    output logic rsp_valid,
    output mpf_csr_pkg::t_tid rsp_tid,
    output mpf_csr_pkg::t_csr_word rsp_data
);

    typedef enum logic [2:0]
    {
        STAT_IDLE,
        STAT_PROCESS,
        STAT_READ_WAIT,
        STAT_ADD_HIGH,
        STAT_WRITEBACK
    } t_stat_state;

    t_stat_state state;
    logic [$clog2(mpf_csr_pkg::NUM_STATS)-1:0] bucket_idx;
    mpf_csr_pkg::t_stat_cnt_vec counts_q;

    // Bucket read through writeback holds off MMIO reads
    logic stat_busy;
    logic mmio_start;
    logic bucket_start;
    logic mmio_active;

    // Add pipeline
    logic carry_q;
    logic [31:0] rd_high_q;

    assign stat_rdy = (state == STAT_IDLE);
    assign stat_busy = (state == STAT_READ_WAIT) || (state == STAT_ADD_HIGH) ||
                       (state == STAT_WRITEBACK);

    // ====================================================================
    // Store access arbitration, MMIO first
    // ====================================================================

    assign mmio_start = req_valid && mem_rd_rdy && !stat_busy;
    assign bucket_start = (state == STAT_PROCESS) && mem_rd_rdy && !req_valid;
    assign req_deq = mmio_start;

    assign mem_rd_en = mmio_start || bucket_start;
    assign mem_rd_idx = mmio_start ? req_offset : mpf_csr_pkg::STAT_OFFSET[bucket_idx];

    assign mem_wr_en = (state == STAT_WRITEBACK) && mem_wr_rdy;
    assign mem_wr_idx = mpf_csr_pkg::STAT_OFFSET[bucket_idx];

    // MMIO response path
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mmio_active <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            if (mmio_start)
                mmio_active <= 1'b1;
            else if (mem_rd_val_valid)
                mmio_active <= 1'b0;

            rsp_valid <= mem_rd_val_valid && mmio_active;
        end

        // TID stays put until the next read starts
        if (mmio_start)
            rsp_tid <= req_tid;
        if (mem_rd_val_valid)
            rsp_data <= mem_rd_val;
    end

    // ====================================================================
    // Statistics FSM: read, add low with carry, add high, write
    // ====================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= STAT_IDLE;
            bucket_idx <= '0;
        end
        else
        begin
            case (state)
                STAT_IDLE:
                begin
                    bucket_idx <= '0;
                    if (stat_upd_en)
                        state <= STAT_PROCESS;
                end
                STAT_PROCESS:
                    if (bucket_start)
                        state <= STAT_READ_WAIT;
                STAT_READ_WAIT:
                    if (mem_rd_val_valid)
                        state <= STAT_ADD_HIGH;
                STAT_ADD_HIGH:
                    state <= STAT_WRITEBACK;
                STAT_WRITEBACK:
                    if (mem_wr_en)
                    begin
                        // Last bucket ends the pass
                        if (bucket_idx == ($bits(bucket_idx))'(mpf_csr_pkg::NUM_STATS - 1))
                            state <= STAT_IDLE;
                        else
                        begin
                            bucket_idx <= bucket_idx + 1'b1;
                            state <= STAT_PROCESS;
                        end
                    end
                default:
                    state <= STAT_IDLE;
            endcase
        end

        if (stat_upd_en && stat_rdy)
            counts_q <= stat_counts;

        if ((state == STAT_READ_WAIT) && mem_rd_val_valid)
        begin
            // Low half plus the bucket count
            {carry_q, mem_wr_val[31:0]} <= {1'b0, mem_rd_val[31:0]} +
                                           33'(counts_q[bucket_idx]);
            rd_high_q <= mem_rd_val[63:32];
        end

        // High half only takes the carry
        if (state == STAT_ADD_HIGH)
            mem_wr_val[63:32] <= rd_high_q + 32'(carry_q);
    end

endmodule

/* logic/mpf_csr_top.sv */
/*
 * CSR read manager top: request FIFO, event accumulators, read engine
 * and the double-pumped CSR store
 */
`timescale 1ns/1ps

module mpf_csr_top
(
    input  logic clk,
    input  logic reset,

    // Host MMIO read strobes
    input  logic mmio_rd_valid,
    input  mpf_csr_pkg::t_mmio_addr mmio_rd_addr,
    input  mpf_csr_pkg::t_tid mmio_rd_tid,

    // Event levels from the shims
    input  logic [mpf_csr_pkg::NUM_STATS-1:0] events,

    // Read responses, no back-pressure
    output logic rsp_valid,
    output mpf_csr_pkg::t_tid rsp_tid,
    output mpf_csr_pkg::t_csr_word rsp_data
);

    // FIFO head toward the engine
    logic req_valid;
    mpf_csr_pkg::t_csr_offset req_offset;
    mpf_csr_pkg::t_tid req_tid;
    logic req_deq;

    // Statistics handoff
    logic stat_rdy;
    logic stat_upd_en;
    mpf_csr_pkg::t_stat_cnt_vec stat_counts;

    // Store ports
    logic mem_rd_rdy;
    logic mem_rd_en;
    mpf_csr_pkg::t_csr_offset mem_rd_idx;
    mpf_csr_pkg::t_csr_word mem_rd_val;
    logic mem_rd_val_valid;
    logic mem_wr_rdy;
    logic mem_wr_en;
    mpf_csr_pkg::t_csr_offset mem_wr_idx;
    mpf_csr_pkg::t_csr_word mem_wr_val;

    mmio_req_fifo #(.DEPTH(64)) req_fifo
    (
        .clk, .reset,
        .mmio_rd_valid, .mmio_rd_addr, .mmio_rd_tid,
        .req_deq, .req_valid, .req_offset, .req_tid
    );

    csr_stat_accum stats
    (
        .clk, .reset,
        .events, .stat_rdy, .stat_upd_en, .stat_counts
    );

    csr_read_engine engine
    (
        .clk, .reset,
        .req_valid, .req_offset, .req_tid, .req_deq,
        .stat_upd_en, .stat_counts, .stat_rdy,
        .mem_rd_rdy, .mem_wr_rdy, .mem_rd_val, .mem_rd_val_valid,
        .mem_rd_en, .mem_rd_idx,
        .mem_wr_en, .mem_wr_idx, .mem_wr_val,
        .rsp_valid, .rsp_tid, .rsp_data
    );

    csr_rd_memory store
    (
        .clk, .reset,
        .mem_rd_en, .mem_rd_idx, .mem_rd_rdy,
        .mem_rd_val, .mem_rd_val_valid,
        .mem_wr_en, .mem_wr_idx, .mem_wr_val, .mem_wr_rdy
    );

endmodule

/* tests/tb_mpf_csr_model.svh */
/*
 * Testbench reference model: expected CSR words, running event tallies
 * and the value check
 */
`ifndef TB_MPF_CSR_MODEL_SVH
`define TB_MPF_CSR_MODEL_SVH

    // One running count per event input, high cycles seen so far
    logic [63:0] tally [mpf_csr_pkg::NUM_STATS];
    int error_count;
    int check_count;

    // Statistics slot of a word, or -1 for a plain CSR word
    function automatic int stat_slot(input mpf_csr_pkg::t_csr_offset off);
        int word;
        int slot;

        word = int'(off);
        slot = -1;
        // VTP counters sit at words 8 to 13, the VC map counter at word 40
        if (word >= 8 && word <= 13)
            slot = word - 8;
        else if (word == 40)
            slot = 6;
        return slot;
    endfunction

    // Word index of statistics slot i
    function automatic int stat_word(input int i);
        return (i < 6) ? 8 + i : 40;
    endfunction

    // Expected content of a CSR word at this point of the run
    function automatic mpf_csr_pkg::t_csr_word expected_word(
        input mpf_csr_pkg::t_csr_offset off);
        int slot;
        mpf_csr_pkg::t_csr_word w;

        slot = stat_slot(off);
        if (slot >= 0)
            w = tally[slot];
        else
            w = mpf_csr_pkg::csr_init_word(off);
        return w;
    endfunction

    // Add one cycle of event levels to the tallies
    function automatic void tally_events(input logic [mpf_csr_pkg::NUM_STATS-1:0] ev);
        for (int i = 0; i < mpf_csr_pkg::NUM_STATS; i++)
            tally[i] = tally[i] + 64'(ev[i]);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

`endif

/* tests/tb_mpf_csr.sv */
/*
 * Testbench for the CSR read manager covering header reads, window
 * filtering, event statistics, accumulator carry and a mixed load
 */
`timescale 1ns/1ps

module tb_mpf_csr;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_OUTSTANDING = 64;
    localparam int DRAIN_LIMIT = 1000;
    localparam int IDLE_CHECK = 200;
    // Three flush intervals
    localparam int FLUSH_WAIT = 3 << mpf_csr_pkg::STAT_FLUSH_INTERVAL_LOG2;
    localparam int STAT_RUN = 3000;
    localparam int HOLD_EVENT = 6;
    // Longer than one 16-bit accumulator wrap
    localparam int HOLD_CYCLES = 70000;
    localparam int MIXED_EVENT_CYCLES = 3000;
    localparam int N_MIXED = 400;

    // Test lengths in cycles used by the watchdog
    localparam int T1_CYCLES = 64 * 3 + DRAIN_LIMIT;
    localparam int T2_CYCLES = 16 * 2 + DRAIN_LIMIT + IDLE_CHECK;
    localparam int T3_CYCLES = STAT_RUN + FLUSH_WAIT + DRAIN_LIMIT;
    localparam int T4_CYCLES = HOLD_CYCLES + FLUSH_WAIT + DRAIN_LIMIT;
    localparam int T5_CYCLES = MIXED_EVENT_CYCLES + N_MIXED * 8 + DRAIN_LIMIT;
    localparam int TOTAL_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
                                  T4_CYCLES + T5_CYCLES;

    // Managed dword window
    localparam int WIN_BASE = mpf_csr_pkg::DFH_MMIO_BASE_ADDR >> 2;
    localparam int WIN_END = WIN_BASE + mpf_csr_pkg::CSR_SIZE64 * 2;

    // Reads just outside and far outside the window
    localparam mpf_csr_pkg::t_mmio_addr BAD_ADDR [8] = '{
        16'h0000, 16'h03fe, 16'h03ff, 16'h0480,
        16'h0481, 16'h0fff, 16'h1400, 16'hffff
    };

    logic clk;
    logic reset;
    logic mmio_rd_valid;
    mpf_csr_pkg::t_mmio_addr mmio_rd_addr;
    mpf_csr_pkg::t_tid mmio_rd_tid;
    logic [mpf_csr_pkg::NUM_STATS-1:0] events;
    logic rsp_valid;
    mpf_csr_pkg::t_tid rsp_tid;
    mpf_csr_pkg::t_csr_word rsp_data;

    // Outstanding reads in request order
    mpf_csr_pkg::t_tid exp_tid_q [$];
    mpf_csr_pkg::t_csr_word exp_data_q [$];
    mpf_csr_pkg::t_tid next_tid;
    integer seed;
    int test_count;

    `include "tb_mpf_csr_model.svh"

    mpf_csr_top dut0
    (
        .clk, .reset,
        .mmio_rd_valid, .mmio_rd_addr, .mmio_rd_tid,
        .events,
        .rsp_valid, .rsp_tid, .rsp_data
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================================================================
    // Stimulus helpers
    // ====================================================================

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic mpf_csr_pkg::t_mmio_addr word_addr(input int off, input logic low);
        return mpf_csr_pkg::t_mmio_addr'(WIN_BASE + off * 2 + int'(low));
    endfunction

    function automatic bit in_window(input mpf_csr_pkg::t_mmio_addr addr);
        return (int'(addr) >= WIN_BASE) && (int'(addr) < WIN_END);
    endfunction

    // One read strobe
    // Expectation queued only for in-window reads
    task automatic issue_read(input mpf_csr_pkg::t_mmio_addr addr);
        mpf_csr_pkg::t_csr_offset off;

        while (exp_tid_q.size() >= MAX_OUTSTANDING)
            next_cycle();
        mmio_rd_valid = 1'b1;
        mmio_rd_addr = addr;
        mmio_rd_tid = next_tid;
        if (in_window(addr))
        begin
            // Both halves come back whatever the low dword bit
            off = mpf_csr_pkg::t_csr_offset'((int'(addr) - WIN_BASE) >> 1);
            exp_tid_q.push_back(next_tid);
            exp_data_q.push_back(expected_word(off));
        end
        next_tid = next_tid + 1'b1;
        next_cycle();
        mmio_rd_valid = 1'b0;
    endtask

    task automatic drive_events(input logic [mpf_csr_pkg::NUM_STATS-1:0] ev);
        events = ev;
        tally_events(ev);
        next_cycle();
    endtask

    // Wait for all outstanding responses up to the drain limit
    task automatic wait_drain();
        int waited;

        waited = 0;
        while (exp_tid_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            next_cycle();
            waited++;
        end
        if (exp_tid_q.size() != 0)
        begin
            $display("Missing %0d responses after waiting %0d cycles",
                     exp_tid_q.size(), DRAIN_LIMIT);
            error_count++;
            exp_tid_q.delete();
            exp_data_q.delete();
        end
    endtask

    task automatic read_stat_words();
        for (int i = 0; i < mpf_csr_pkg::NUM_STATS; i++)
            issue_read(word_addr(stat_word(i), 1'b0));
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int errs;

        errs = error_count - errs_before;
        test_count++;
        if (errs == 0)
            $display("Test %0d %s: ok", test_count, name);
        else
            $display("Test %0d %s: %0d errors", test_count, name, errs);
    endtask

    // ====================================================================
    // Tests
    // ====================================================================

    // Spaced reads so that the first ones land during the init sweep
    task automatic sweep_header_words();
        logic [31:0] rnd;

        for (int off = 0; off < mpf_csr_pkg::CSR_SIZE64; off++)
        begin
            rnd = $random(seed);
            issue_read(word_addr(off, rnd[0]));
            repeat (2) next_cycle();
        end
        wait_drain();
    endtask

    // Bad reads interleaved with good ones
    // A stray response shows up as a TID error
    task automatic probe_window_edges();
        for (int i = 0; i < 8; i++)
        begin
            issue_read(BAD_ADDR[i]);
            issue_read(word_addr(i * 8 + 1, 1'(i)));
        end
        wait_drain();
        repeat (IDLE_CHECK) next_cycle();
    endtask

    task automatic stream_random_events();
        logic [31:0] rnd;

        repeat (STAT_RUN)
        begin
            rnd = $random(seed);
            drive_events(rnd[mpf_csr_pkg::NUM_STATS-1:0]);
        end
        events = '0;
        repeat (FLUSH_WAIT) next_cycle();
        read_stat_words();
        wait_drain();
    endtask

    task automatic hold_single_event();
        logic [mpf_csr_pkg::NUM_STATS-1:0] ev;

        ev = '0;
        ev[HOLD_EVENT] = 1'b1;
        repeat (HOLD_CYCLES) drive_events(ev);
        events = '0;
        repeat (FLUSH_WAIT) next_cycle();
        read_stat_words();
        wait_drain();
    endtask

    // Back-to-back reads of non-statistics words while events run
    task automatic mix_reads_with_events();
        integer ev_seed;
        logic [31:0] ev_rnd;
        logic [31:0] rd_rnd;

        ev_seed = $random(seed);
        fork
            begin
                repeat (MIXED_EVENT_CYCLES)
                begin
                    ev_rnd = $random(ev_seed);
                    drive_events(ev_rnd[mpf_csr_pkg::NUM_STATS-1:0]);
                end
                events = '0;
            end
            begin
                for (int n = 0; n < N_MIXED; n++)
                begin
                    do
                        rd_rnd = $random(seed);
                    while (stat_slot(rd_rnd[5:0]) >= 0);
                    issue_read(word_addr(int'(rd_rnd[5:0]), rd_rnd[6]));
                end
            end
        join
        wait_drain();
    endtask

    // ====================================================================
    // Response compare at the falling edge
    // ====================================================================

    initial
    begin : compare_responses
        mpf_csr_pkg::t_tid exp_tid;
        mpf_csr_pkg::t_csr_word exp_data;

        forever
        begin
            @(negedge clk);
            if (rsp_valid)
            begin
                if (exp_tid_q.size() == 0)
                begin
                    $display("Unexpected response with TID 0x%0h while no read is outstanding",
                             rsp_tid);
                    error_count++;
                end
                else
                begin
                    exp_tid = exp_tid_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    check_value("rsp_tid", 64'(rsp_tid), 64'(exp_tid));
                    check_value("rsp_data", rsp_data, exp_data);
                end
            end
        end
    end

    initial
    begin : watchdog
        repeat (2 * TOTAL_CYCLES) @(posedge clk);
        $display("Watchdog timeout after %0d cycles, the run did not finish",
                 2 * TOTAL_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin : main_flow
        int errs_before;

        seed = 32'h4460;
        reset = 1'b1;
        mmio_rd_valid = 1'b0;
        mmio_rd_addr = '0;
        mmio_rd_tid = '0;
        events = '0;
        next_tid = '0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        for (int i = 0; i < mpf_csr_pkg::NUM_STATS; i++)
            tally[i] = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        errs_before = error_count;
        sweep_header_words();
        finish_test("header reads", errs_before);

        errs_before = error_count;
        probe_window_edges();
        finish_test("window filter", errs_before);

        errs_before = error_count;
        stream_random_events();
        finish_test("statistics", errs_before);

        errs_before = error_count;
        hold_single_event();
        finish_test("accumulator carry", errs_before);

        errs_before = error_count;
        mix_reads_with_events();
        finish_test("mixed load", errs_before);

        $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+tests
logic/mpf_csr_pkg.sv
logic/mmio_req_fifo.sv
logic/csr_stat_accum.sv
logic/csr_rd_memory.sv
logic/csr_read_engine.sv
logic/mpf_csr_top.sv
tests/tb_mpf_csr.sv

/* Makefile */
# Verilator build and run for the CSR read manager testbench
# Any variable below can be set on the command line

VERILATOR ?= verilator
TOP ?= tb_mpf_csr
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/1ps -j 0

PASS_MSG = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
